// File: list.f
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/inst_rom.sv
verilog/rv_core.sv
verilog/cpu_top.sv
dv/store_checker.sv
dv/cpu_props.sv
dv/cpu_tb.sv

// File: run.sh
#!/bin/sh
set -e

rm -rf obj_dir
verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim

# the simulator may stop early on a failed assertion, the log still decides
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  exit 1
fi

// File: program.hex
// one 32-bit instruction word per line, from word address 0 upward
00500093
00708113
002081B3
40208233
04402023
40125313
04602223
123452B7
00022393
007282B3
00029463
04102623
04502423
F8000393
047008A3
05100403
05104483
40848533
04A02A23
04802C23
008005EF
04002E23
05802603
018586E7
06002023
06002023
00000013
06D02023
06C02223
0000C463
10102023
0000006F

// File: dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import rv_pkg::*; ();

  logic      clk;
  logic      reset;
  dmem_req_t dmem_req;
  logic      mem_ready;
  word_t     mem_rdata;
  logic      mem_valid;
  int        errors, stores_seen, stores_expected;
  logic      sig_seen;

  logic [7:0] mem [1024];  // data memory, bytes
  logic       load_pending;
  word_t      load_addr;
  logic       timed_out;
  int         cycles;

  cpu_top #(.rom_addr_bits(6)) uut (
    .clk      (clk),
    .reset    (reset),
    .dmem_req (dmem_req),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .mem_valid(mem_valid)
  );

  store_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .dmem_req       (dmem_req),
    .mem_ready      (mem_ready),
    .errors         (errors),
    .stores_seen    (stores_seen),
    .stores_expected(stores_expected),
    .sig_seen       (sig_seen)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // accepted requests, sampled on the rising edge
  always @(posedge clk) begin
    if (!reset && (|dmem_req.oe) && mem_ready) begin
      if (|dmem_req.we) begin
        for (int k = 0; k < 4; k++)
          if (dmem_req.we[k]) mem[{dmem_req.addr[9:2], 2'(k)}] = dmem_req.wdata[8*k +: 8];
      end else begin
        load_pending = 1'b1;
        load_addr = dmem_req.addr;
      end
    end
  end

  always @(negedge clk) begin
    mem_ready = (reset == 1'b0) && ($urandom % 3 != 0);  // low about a third
    mem_valid = load_pending;
    if (load_pending)
      mem_rdata = {mem[{load_addr[9:2], 2'd3}], mem[{load_addr[9:2], 2'd2}],
                   mem[{load_addr[9:2], 2'd1}], mem[{load_addr[9:2], 2'd0}]};
    load_pending = 1'b0;
  end

  initial begin
    void'($urandom(32'h6a78));
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    mem_valid = 1'b0;
    load_pending = 1'b0;
    load_addr = '0;
    timed_out = 1'b0;
    for (int i = 0; i < 1024; i++) mem[i] = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    cycles = 0;
    while (!sig_seen && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    if (!sig_seen) begin
      timed_out = 1'b1;
      $display("timeout waiting for the store to the signature address");
    end
    repeat (40) @(negedge clk);  // room for any stray store

    $display("errors: %0d, stores seen: %0d of %0d", errors, stores_seen, stores_expected);
    if (errors == 0 && !timed_out && stores_seen == stores_expected) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props import rv_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      imem_oe,
  input logic      imem_valid,
  input dmem_req_t dmem_req
);

  we_in_oe: assert property (@(posedge clk) disable iff (reset)
    (dmem_req.we & ~dmem_req.oe) == 4'b0000)
    else $error("write lanes outside the enabled lanes");

  store_lanes: assert property (@(posedge clk) disable iff (reset)
    dmem_req.we != 4'b0000 |-> dmem_req.we inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111})
    else $error("store with an illegal lane pattern");

  valid_after_read: assert property (@(posedge clk) disable iff (reset)
    imem_oe |=> imem_valid)
    else $error("instruction read without a valid pulse");

  no_valid_unread: assert property (@(posedge clk) disable iff (reset)
    !imem_oe |=> !imem_valid)
    else $error("valid pulse without an instruction read");

  idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> dmem_req.oe == 4'b0000)
    else $error("data request active right after reset");

endmodule

bind rv_core cpu_props u_props (
  .clk       (clk),
  .reset     (reset),
  .imem_oe   (imem_oe),
  .imem_valid(imem_valid),
  .dmem_req  (dmem_req)
);

`default_nettype wire

// File: dv/store_checker.sv
`timescale 1ns/1ps
`default_nettype none

module store_checker import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  dmem_req_t dmem_req,
  input  logic      mem_ready,
  output int        errors,
  output int        stores_seen,
  output int        stores_expected,
  output logic      sig_seen
);

  word_t prog [64];
  word_t exp_addr [$];
  strb_t exp_we [$];
  word_t exp_data [$];
  word_t ld_addr [$];  // expected loads, in program order
  strb_t ld_oe [$];
  int    loads_seen;
  logic  reset_q;      // reset seen on the previous edge

  function automatic word_t alu_ref(logic is_reg, word_t ir, word_t a, word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (ir[14:12])
      3'd0: return (is_reg && ir[30]) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return ir[30] ? word_t'($signed(a) >>> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs the program one instruction at a time and records each store
  function automatic void run_reference();
    word_t x [32];
    logic [7:0] dm [1024];
    word_t pc, ir, a, b, res, nxt, addr, iimm, simm, bimm, jimm;
    logic wr, take, done;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 1024; i++) dm[i] = '0;
    pc = '0;
    done = 1'b0;
    for (int step = 0; step < 2000 && !done; step++) begin
      ir = prog[pc[7:2]];
      a = x[ir[19:15]];
      b = x[ir[24:20]];
      iimm = {{20{ir[31]}}, ir[31:20]};
      simm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      bimm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      jimm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      nxt = pc + 32'd4;
      wr = 1'b1;
      res = '0;
      addr = a + ((ir[6:0] == 7'h23) ? simm : iimm);
      case (ir[6:0])
        7'h37: res = {ir[31:12], 12'b0};
        7'h17: res = pc + {ir[31:12], 12'b0};
        7'h6f: begin
          res = pc + 32'd4;
          nxt = pc + jimm;
        end
        7'h67: begin
          res = pc + 32'd4;
          nxt = (a + iimm) & ~32'd1;
        end
        7'h63: begin
          wr = 1'b0;
          case (ir[14:12])
            3'd0: take = a == b;
            3'd1: take = a != b;
            3'd4: take = $signed(a) < $signed(b);
            3'd5: take = $signed(a) >= $signed(b);
            3'd6: take = a < b;
            default: take = a >= b;
          endcase
          if (take) nxt = pc + bimm;
        end
        7'h13: res = alu_ref(1'b0, ir, a, iimm);
        7'h33: res = alu_ref(1'b1, ir, a, b);
        7'h03: begin
          ld_addr.push_back(addr);
          ld_oe.push_back((ir[14:12] == 3'd2) ? 4'b1111 : strb_t'(4'b0001 << addr[1:0]));
          if (ir[14:12] == 3'd0) res = {{24{dm[addr[9:0]][7]}}, dm[addr[9:0]]};
          else if (ir[14:12] == 3'd4) res = {24'b0, dm[addr[9:0]]};
          else res = {dm[addr[9:0] + 3], dm[addr[9:0] + 2], dm[addr[9:0] + 1],
                      dm[addr[9:0]]};
        end
        7'h23: begin
          wr = 1'b0;
          exp_addr.push_back(addr);
          if (ir[14:12] == 3'd0) begin
            dm[addr[9:0]] = b[7:0];
            exp_we.push_back(strb_t'(4'b0001 << addr[1:0]));
            exp_data.push_back({4{b[7:0]}});
          end else begin
            for (int k = 0; k < 4; k++) dm[addr[9:0] + k] = b[8*k +: 8];
            exp_we.push_back(4'b1111);
            exp_data.push_back(b);
          end
          done = addr == 32'h100;  // signature store ends the program
        end
        default: wr = 1'b0;
      endcase
      if (wr && ir[11:7] != 5'd0) x[ir[11:7]] = res;
      pc = nxt;
    end
  endfunction

  initial begin
    errors = 0;
    stores_seen = 0;
    loads_seen = 0;
    reset_q = 1'b0;
    sig_seen = 1'b0;
    for (int i = 0; i < 64; i++) prog[i] = nop_instr;
    $readmemh("program.hex", prog);
    run_reference();
    stores_expected = exp_addr.size();
  end

  always @(posedge clk) begin
    if (reset) begin
      if (reset_q && (dmem_req.oe !== 4'b0000 || dmem_req.we !== 4'b0000)) begin
        $display("** Error: dmem_req.oe = %h, dmem_req.we = %h during reset, expected 0",
                 dmem_req.oe, dmem_req.we);
        errors++;
      end
    end else if ((|dmem_req.we) && mem_ready) begin
      if (stores_seen >= exp_addr.size()) begin
        $display("store to %h after the last expected store", dmem_req.addr);
        errors++;
      end else begin
        if (dmem_req.addr !== exp_addr[stores_seen]) begin
          $display("** Error: dmem_req.addr = %h, expected %h", dmem_req.addr,
                   exp_addr[stores_seen]);
          errors++;
        end
        if (dmem_req.we !== exp_we[stores_seen]) begin
          $display("** Error: dmem_req.we = %h, expected %h", dmem_req.we,
                   exp_we[stores_seen]);
          errors++;
        end
        if (dmem_req.oe !== exp_we[stores_seen]) begin
          $display("** Error: dmem_req.oe = %h, expected %h", dmem_req.oe,
                   exp_we[stores_seen]);
          errors++;
        end
        if (dmem_req.wdata !== exp_data[stores_seen]) begin
          $display("** Error: dmem_req.wdata = %h, expected %h", dmem_req.wdata,
                   exp_data[stores_seen]);
          errors++;
        end
        if (stores_seen == exp_addr.size() - 1) sig_seen = 1'b1;
      end
      stores_seen++;
    end else if ((|dmem_req.oe) && mem_ready) begin
      if (loads_seen >= ld_addr.size()) begin
        $display("load from %h after the last expected load", dmem_req.addr);
        errors++;
      end else begin
        if (dmem_req.addr !== ld_addr[loads_seen]) begin
          $display("** Error: dmem_req.addr = %h, expected %h", dmem_req.addr,
                   ld_addr[loads_seen]);
          errors++;
        end
        if (dmem_req.oe !== ld_oe[loads_seen]) begin
          $display("** Error: dmem_req.oe = %h, expected %h", dmem_req.oe,
                   ld_oe[loads_seen]);
          errors++;
        end
      end
      loads_seen++;
    end
    reset_q <= reset;
  end

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import rv_pkg::*; #(
  parameter int rom_addr_bits = 6
) (
  input  logic      clk,
  input  logic      reset,
  output dmem_req_t dmem_req,
  input  logic      mem_ready,
  input  word_t     mem_rdata,
  input  logic      mem_valid
);

  logic [rom_addr_bits-1:0] imem_addr;
  logic                     imem_oe;
  word_t                    imem_rdata;
  logic                     imem_valid;

  rv_core #(.rom_addr_bits(rom_addr_bits)) u_core (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_oe   (imem_oe),
    .imem_rdata(imem_rdata),
    .imem_valid(imem_valid),
    .dmem_req  (dmem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid)
  );

  inst_rom #(.rom_addr_bits(rom_addr_bits)) u_rom (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_oe   (imem_oe),
    .imem_rdata(imem_rdata),
    .imem_valid(imem_valid)
  );

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter int rom_addr_bits = 6
) (
  input  logic                     clk,
  input  logic                     reset,
  output logic [rom_addr_bits-1:0] imem_addr,
  output logic                     imem_oe,
  input  word_t                    imem_rdata,
  input  logic                     imem_valid,
  output dmem_req_t                dmem_req,
  input  logic                     mem_ready,
  input  word_t                    mem_rdata,
  input  logic                     mem_valid
);

  function automatic word_t iimm(word_t ir);
    return {{20{ir[31]}}, ir[31:20]};
  endfunction

  function automatic logic writes_rd(word_t ir);
    opcode_e op;
    op = opcode_e'(ir[6:2]);
    return ir[11:7] != 5'd0 && op != op_store && op != op_branch;
  endfunction

  logic req_id, req_em, req_wb;              // per-stage stall requests
  logic stall_if, stall_id, stall_em, stall_wb;
  logic bubble_em, bubble_wb;                // nop into the named stage
  logic flush, em_taken;
  word_t btarget;

  // a request holds every earlier stage, the bubble goes in right behind it
  assign stall_wb = req_wb;
  assign stall_em = req_em | stall_wb;
  assign stall_id = req_id | stall_em;
  assign stall_if = stall_id;  // fetch has no request of its own
  assign bubble_em = req_id & ~stall_em;
  assign bubble_wb = req_em & ~stall_wb;

  // fetch
  word_t pc_if, pc_id_q;
  logic  imem_reading, id_kill;

  always_ff @(posedge clk) begin
    if (reset) pc_if <= '0;
    else if (flush) pc_if <= btarget;  // not-taken prediction
    else if (!stall_if) pc_if <= pc_if + 32'd4;
  end

  assign imem_addr = pc_if[rom_addr_bits+1:2];
  assign imem_oe = !stall_if;

  always_ff @(posedge clk) begin
    if (reset) imem_reading <= 1'b0;
    else if (imem_oe) imem_reading <= 1'b1;
    else if (imem_valid) imem_reading <= 1'b0;
  end

  // decode slot squashed after reset or a taken transfer, held while stalled
  always_ff @(posedge clk) begin
    if (reset || flush) id_kill <= 1'b1;
    else if (!stall_id) id_kill <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!stall_id) pc_id_q <= pc_if;  // address of the word arriving next cycle
  end

  // decode
  stage_t   s_id, s_em, s_wb;
  opcode_e  id_op;
  reg_idx_t rf_rs1, rf_rs2;
  word_t    rf_rdata1, rf_rdata2, wb_value;
  word_t    rs1_q, rs2_q;
  word_t    tgt_jal, tgt_jalr, tgt_br;
  logic [7:0] bcond;
  logic     rf_we;

  assign s_id.pc = pc_id_q;
  assign s_id.ir = id_kill ? nop_instr : imem_rdata;
  assign id_op = opcode_e'(s_id.ir[6:2]);

  // while execute waits, keep its operands fresh from the write-through
  assign rf_rs1 = stall_em ? s_em.ir[19:15] : s_id.ir[19:15];
  assign rf_rs2 = stall_em ? s_em.ir[24:20] : s_id.ir[24:20];

  reg_file u_rf (
    .clk   (clk),
    .reset (reset),
    .rs1   (rf_rs1),
    .rs2   (rf_rs2),
    .rdata1(rf_rdata1),
    .rdata2(rf_rdata2),
    .rd    (s_wb.ir[11:7]),
    .wdata (wb_value),
    .we    (rf_we)
  );

  always_ff @(posedge clk) begin
    rs1_q <= rf_rdata1;
    rs2_q <= rf_rdata2;
  end

  // targets and conditions ready before the branch reaches execute
  always_ff @(posedge clk) begin
    if (!stall_em) begin
      tgt_jal <= s_id.pc + {{12{s_id.ir[31]}}, s_id.ir[19:12], s_id.ir[20],
                            s_id.ir[30:21], 1'b0};
      tgt_jalr <= rf_rdata1 + iimm(s_id.ir);
      tgt_br <= s_id.pc + {{20{s_id.ir[31]}}, s_id.ir[7], s_id.ir[30:25],
                           s_id.ir[11:8], 1'b0};
      bcond <= '0;
      bcond[f3_beq] <= rf_rdata1 == rf_rdata2;
      bcond[f3_bne] <= rf_rdata1 != rf_rdata2;
      bcond[f3_blt] <= $signed(rf_rdata1) < $signed(rf_rdata2);
      bcond[f3_bge] <= $signed(rf_rdata1) >= $signed(rf_rdata2);
      bcond[f3_bltu] <= rf_rdata1 < rf_rdata2;
      bcond[f3_bgeu] <= rf_rdata1 >= rf_rdata2;
    end
  end

  // missing fetch, or branch/jalr source still in execute
  assign req_id = (imem_reading && !imem_valid) ||
                  ((id_op == op_branch || id_op == op_jalr) && writes_rd(s_em.ir) &&
                   (s_em.ir[11:7] == s_id.ir[19:15] || s_em.ir[11:7] == s_id.ir[24:20]));

  always_ff @(posedge clk) begin
    if (reset || flush || bubble_em) s_em.ir <= nop_instr;
    else if (!stall_em) s_em.ir <= s_id.ir;
    if (!stall_em) s_em.pc <= s_id.pc;
  end

  // execute and memory
  opcode_e em_op;
  funct3_t em_f3;
  word_t   fwd1, fwd2, alu_opd2, alu_result, mem_addr;
  strb_t   lanes;
  logic    em_store, em_mem, req_pend, req_acc, issue;

  assign em_op = opcode_e'(s_em.ir[6:2]);
  assign em_f3 = s_em.ir[14:12];

  // write-back forwarding
  assign fwd1 = (writes_rd(s_wb.ir) && s_wb.ir[11:7] == s_em.ir[19:15]) ? wb_value : rs1_q;
  assign fwd2 = (writes_rd(s_wb.ir) && s_wb.ir[11:7] == s_em.ir[24:20]) ? wb_value : rs2_q;
  assign alu_opd2 = (em_op == op_op) ? fwd2 : iimm(s_em.ir);

  alu u_alu (
    .opcode  (em_op),
    .funct3  (em_f3),
    .funct7_5(s_em.ir[30]),
    .opd1    (fwd1),
    .opd2    (alu_opd2),
    .result  (alu_result)
  );

  assign em_taken = em_op == op_jal || em_op == op_jalr ||
                    (em_op == op_branch && bcond[em_f3]);
  assign btarget = ~32'd1 & ((em_op == op_jal)  ? tgt_jal  :
                             (em_op == op_jalr) ? tgt_jalr : tgt_br);
  assign flush = em_taken && !stall_em;  // kills decode and fetch

  assign em_store = em_op == op_store;
  assign em_mem = em_store || em_op == op_load;
  assign mem_addr = fwd1 + (em_store ? {{20{s_em.ir[31]}}, s_em.ir[31:25], s_em.ir[11:7]}
                                     : iimm(s_em.ir));
  assign lanes = (em_f3 == f3_word) ? 4'b1111 : 4'b0001 << mem_addr[1:0];

  assign req_pend = |dmem_req.oe;
  assign req_acc = req_pend && mem_ready;              // the one transfer cycle
  assign issue = em_mem && !req_pend && !stall_wb;
  assign req_em = em_mem && !req_acc;                  // first cycle always waits

  always_ff @(posedge clk) begin
    if (issue) begin
      dmem_req.addr <= mem_addr;
      dmem_req.wdata <= (em_f3 == f3_word) ? fwd2 : {4{fwd2[7:0]}};
    end
    if (reset || req_acc) begin
      dmem_req.oe <= '0;
      dmem_req.we <= '0;
    end else if (issue) begin
      dmem_req.oe <= lanes;
      dmem_req.we <= em_store ? lanes : 4'b0000;
    end
  end

  // write-back
  opcode_e    wb_op;
  funct3_t    wb_f3;
  word_t      alu_q, upper_q, load_word, load_val;
  logic [1:0] load_off;

  always_ff @(posedge clk) begin
    if (reset || bubble_wb) s_wb.ir <= nop_instr;
    else if (!stall_wb) s_wb.ir <= s_em.ir;
    if (!stall_wb) begin
      s_wb.pc <= s_em.pc;
      alu_q <= alu_result;
      upper_q <= {s_em.ir[31:12], 12'b0} + ((em_op == op_auipc) ? s_em.pc : '0);
      load_off <= dmem_req.addr[1:0];  // accepted request of this load
    end
  end

  assign wb_op = opcode_e'(s_wb.ir[6:2]);
  assign wb_f3 = s_wb.ir[14:12];
  assign req_wb = wb_op == op_load && !mem_valid;  // load data not back yet

  assign load_word = mem_rdata >> {load_off, 3'b000};
  assign load_val = (wb_f3 == f3_byte)   ? {{24{load_word[7]}}, load_word[7:0]} :
                    (wb_f3 == f3_byte_u) ? {24'b0, load_word[7:0]} : mem_rdata;

  always_comb begin
    case (wb_op)
      op_load:          wb_value = load_val;
      op_lui, op_auipc: wb_value = upper_q;
      op_jal, op_jalr:  wb_value = s_wb.pc + 32'd4;  // link
      default:          wb_value = alu_q;
    endcase
  end

  assign rf_we = writes_rd(s_wb.ir) && !stall_wb;

endmodule

`default_nettype wire

// File: verilog/inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom import rv_pkg::*; #(
  parameter int rom_addr_bits = 6
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [rom_addr_bits-1:0] imem_addr,  // word address
  input  logic                     imem_oe,
  output word_t                    imem_rdata,
  output logic                     imem_valid
);

  word_t rom [2**rom_addr_bits];

  initial begin
    for (int i = 0; i < 2**rom_addr_bits; i++) rom[i] = nop_instr;  // past end of program
    $readmemh("program.hex", rom);
  end

  always_ff @(posedge clk) begin
    if (imem_oe) imem_rdata <= rom[imem_addr];  // held while no read
  end

  always_ff @(posedge clk) begin
    if (reset) imem_valid <= 1'b0;
    else imem_valid <= imem_oe;  // one pulse per read
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
  input  opcode_e opcode,
  input  funct3_t funct3,
  input  logic    funct7_5,
  input  word_t   opd1,
  input  word_t   opd2,
  output word_t   result
);

  logic [4:0] shamt;
  logic       sub;

  assign shamt = opd2[4:0];
  assign sub = (opcode == op_op) && funct7_5;  // addi has no subtract form

  always_comb begin
    case (funct3)
      3'b000: result = sub ? opd1 - opd2 : opd1 + opd2;
      3'b001: result = opd1 << shamt;
      3'b010: result = {31'b0, $signed(opd1) < $signed(opd2)};
      3'b011: result = {31'b0, opd1 < opd2};
      3'b100: result = opd1 ^ opd2;
      3'b101: begin
        // funct7 bit 5 picks arithmetic shift for both forms
        if (funct7_5) result = word_t'($signed(opd1) >>> shamt);
        else result = opd1 >> shamt;
      end
      3'b110: result = opd1 | opd2;
      default: result = opd1 & opd2;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rdata1,
  output word_t    rdata2,
  input  reg_idx_t rd,
  input  word_t    wdata,
  input  logic     we
);

  word_t regs [1:31];  // x0 is not stored

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // write value shows up on a read of the same register in the same cycle
  assign rdata1 = (rs1 == 5'd0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;     // data word or byte address
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  strb_t;     // one bit per byte lane
  typedef logic [2:0]  funct3_t;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_opimm  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_op     = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011
  } opcode_e;

  // branch conditions, indexed by funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load/store widths
  localparam funct3_t f3_byte   = 3'b000;  // lb, sb
  localparam funct3_t f3_word   = 3'b010;  // lw, sw
  localparam funct3_t f3_byte_u = 3'b100;  // lbu

  // data memory request, valid while oe is nonzero
  typedef struct packed {
    word_t addr;
    word_t wdata;
    strb_t oe;
    strb_t we;
  } dmem_req_t;

  // one pipeline register
  typedef struct packed {
    word_t pc;
    word_t ir;
  } stage_t;

  localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire
